// ==== hdl/ethSwitchPkg.sv ====
//##########################################################
// Ethernet switch address path definitions
// Port roles, FPGA MAC address fields, widths and the
// structs shared by the parsers, deciders and control
//##########################################################

package ethSwitchPkg;

  localparam int NumPorts = 4;                 // All ports run on RxClk

  // Port roles, fixed by board wiring
  localparam int PortEth1 = 0;
  localparam int PortEth2 = 1;
  localparam int PortPs   = 2;                 // Processor side
  localparam int PortRt   = 3;                 // Real-time side

  typedef logic [7:0]          byteT;
  typedef logic [47:0]         macT;
  typedef logic [3:0]          boardIdT;
  typedef logic [NumPorts-1:0] portMaskT;      // Bit i is port i
  typedef logic [15:0]         boardMaskT;     // Bit b is board id b

  localparam macT BroadcastMac = '1;

  // FPGA MAC is company id, 16-bit interface field, board id in low byte
  localparam logic [23:0] CompanyId      = 24'hFA610E;
  localparam logic [23:0] CompanyIdMcast = CompanyId | 24'h010000;  // Group bit
  localparam logic [15:0] PsMid          = 16'h0300;
  localparam logic [15:0] RtMid          = 16'h1394;

  localparam byteT SfdByte     = 8'hD5;        // Start of frame delimiter
  localparam int   HeaderBytes = 14;           // Dest MAC, src MAC, type

  typedef struct packed {
    logic valid;
    byteT data;
  } rxByteT;

  typedef struct packed {
    macT destMac;
    macT srcMac;
  } hdrInfoT;

  typedef struct packed {
    macT       [1:0] hostMac;                  // Index PortEth1, PortEth2
    boardMaskT [1:0] ethAction;                // Boards forwarded per Eth port
  } fwdTableT;

  typedef enum logic [1:0] {
    RxIdle,
    RxHeader,
    RxData
  } rxStateT;

endpackage

// ==== hdl/rxHeaderParser.sv ====
//##########################################################
// Receive header parser for one switch port
// Finds the start of frame byte and captures the MAC part
// of the 14-byte header, then strobes hdrValid once
//##########################################################

module rxHeaderParser import ethSwitchPkg::*; (
  input  logic    RxClk,
  input  logic    arstN,
  input  rxByteT  rx,
  output logic    hdrValid,
  output hdrInfoT hdr
);

  // Dest and src MAC come first, type bytes are skipped
  localparam int MacBytes = $bits(hdrInfoT) / 8;

  rxByteT     rxQ;                             // Input flop on the port pins
  rxStateT    state;
  logic [3:0] byteCnt;                         // Header byte index
  hdrInfoT    hdrShift;                        // MAC bytes as they arrive
  logic       lastByte;

  // 14th header byte present in the input flop
  assign lastByte = (state == RxHeader) && rxQ.valid &&
                    (byteCnt == 4'(HeaderBytes - 1));

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      rxQ      <= '0;
      state    <= RxIdle;
      byteCnt  <= '0;
      hdrValid <= 1'b0;
    end else begin
      rxQ      <= rx;
      hdrValid <= 1'b0;                        // Single cycle strobe
      case (state)
        RxIdle: begin
          byteCnt <= '0;
          // Preamble bytes pass without checks
          if (rxQ.valid && (rxQ.data == SfdByte)) begin
            state <= RxHeader;
          end
        end
        RxHeader: begin
          if (!rxQ.valid) begin
            state <= RxIdle;                   // Header cut short, no strobe
          end else begin
            byteCnt <= byteCnt + 4'd1;
            if (lastByte) begin
              hdrValid <= 1'b1;
              state    <= RxData;
            end
          end
        end
        RxData: begin
          if (!rxQ.valid) begin
            state <= RxIdle;                   // End of frame
          end
        end
        default: state <= RxIdle;
      endcase
    end
  end

  // Header capture
  always_ff @(posedge RxClk) begin
    if ((state == RxHeader) && rxQ.valid && (byteCnt < 4'(MacBytes))) begin
      hdrShift <= {hdrShift[$bits(hdrInfoT)-9:0], rxQ.data};  // First byte ends up on top
    end
    if (lastByte) begin
      hdr <= hdrShift;                         // Held until the next header completes
    end
  end

endmodule

// ==== hdl/fwdDecide.sv ====
//##########################################################
// Out-port decision for one in-port
// Matches the destination MAC against broadcast, FPGA
// multicast, primary addresses and learned FPGA boards
//##########################################################

module fwdDecide import ethSwitchPkg::*; #(
  parameter int InPort = 0
) (
  input  hdrInfoT  hdr,
  input  fwdTableT fwdTable,
  input  boardIdT  boardId,
  input  portMaskT portActive,
  output portMaskT mask
);

  macT      [NumPorts-1:0] primary;            // Primary address per out-port
  portMaskT                primMatch;
  portMaskT                fpgaMatch;          // Only Eth bits can be set
  logic                    isBcast;
  logic                    isMcast;
  logic                    isFpgaDest;
  logic                    noMatch;

  // Hosts are learned, FPGA interfaces follow the board id
  assign primary[PortEth1] = fwdTable.hostMac[PortEth1];
  assign primary[PortEth2] = fwdTable.hostMac[PortEth2];
  assign primary[PortPs]   = {CompanyId, PsMid, 4'd0, boardId};
  assign primary[PortRt]   = {CompanyId, RtMid, 4'd0, boardId};

  assign isBcast    = (hdr.destMac == BroadcastMac);
  // Any middle field is accepted for the FPGA multicast
  assign isMcast    = (hdr.destMac[47:24] == CompanyIdMcast) && (hdr.destMac[7:0] == 8'hFF);
  assign isFpgaDest = (hdr.destMac[47:24] == CompanyId);

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      primMatch[p] = (p != InPort) && (hdr.destMac == primary[p]);  // Own port never matches
    end
  end

  // Board bit taken from the low nibble of the destination
  assign fpgaMatch[PortEth1] = isFpgaDest && fwdTable.ethAction[PortEth1][hdr.destMac[3:0]];
  assign fpgaMatch[PortEth2] = isFpgaDest && fwdTable.ethAction[PortEth2][hdr.destMac[3:0]];
  assign fpgaMatch[PortPs]   = 1'b0;
  assign fpgaMatch[PortRt]   = 1'b0;

  // Unknown destination, flooded to the host ports
  assign noMatch = !(|primMatch) && !(|fpgaMatch);

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      logic hit;
      hit = isBcast || isMcast || primMatch[p];
      if ((p == PortEth1) || (p == PortEth2)) begin
        hit = hit || fpgaMatch[p] || noMatch;  // Eth ports also take FPGA and unknown traffic
      end
      mask[p] = hit && portActive[p] && (p != InPort);
    end
  end

endmodule

// ==== hdl/fwdControl.sv ====
//##########################################################
// Forwarding control
// Learns host and FPGA addresses on Eth1 and Eth2, builds
// the forwarding table and registers the decision strobes
//##########################################################

module fwdControl import ethSwitchPkg::*; (
  input  logic                    RxClk,
  input  logic                    arstN,
  input  boardIdT                 boardId,
  input  portMaskT                portActive,
  input  portMaskT                hdrValid,
  input  hdrInfoT  [NumPorts-1:0] hdrs,
  input  portMaskT [NumPorts-1:0] masks,
  output fwdTableT                fwdTable,
  output portMaskT                fwdValid,
  output portMaskT [NumPorts-1:0] fwdMask
);

  macT       [1:0] hostMac;                    // Last source seen per Eth port
  boardMaskT [1:0] learned;                    // FPGA boards reachable per Eth port
  boardMaskT       ownBoard;
  boardMaskT       unclaimed;

  // Decision registers, one strobe per in-port
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      fwdValid <= '0;
      fwdMask  <= '0;
    end else begin
      fwdValid <= hdrValid;
      for (int p = 0; p < NumPorts; p++) begin
        if (hdrValid[p]) begin
          fwdMask[p] <= masks[p];              // Held until the next strobe
        end
      end
    end
  end

  // Learning, same edge as the fwdValid rise
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      hostMac <= {BroadcastMac, BroadcastMac};
      learned <= '0;
    end else begin
      for (int e = PortEth1; e <= PortEth2; e++) begin
        if (!portActive[e]) begin
          // Link down forgets everything behind the port
          hostMac[e] <= BroadcastMac;
          learned[e] <= '0;
        end else if (hdrValid[e]) begin
          hostMac[e] <= hdrs[e].srcMac;
          if (hdrs[e].srcMac[47:24] == CompanyId) begin
            learned[e][hdrs[e].srcMac[3:0]] <= 1'b1;  // Either interface field counts
          end
        end
      end
    end
  end

  assign ownBoard  = boardMaskT'(1) << boardId;
  // Boards not seen anywhere go out both Eth ports, except this board
  assign unclaimed = ~(learned[PortEth1] | learned[PortEth2] | ownBoard);

  assign fwdTable.hostMac              = hostMac;
  assign fwdTable.ethAction[PortEth1]  = learned[PortEth1] | unclaimed;
  assign fwdTable.ethAction[PortEth2]  = learned[PortEth2] | unclaimed;

endmodule

// ==== hdl/ethSwitchTop.sv ====
//##########################################################
// Four-port Ethernet switch address path
// Per-port header parsers and deciders around the shared
// learning and decision control
//##########################################################

module ethSwitchTop import ethSwitchPkg::*; (
  input  logic                    RxClk,
  input  logic                    arstN,
  input  rxByteT   [NumPorts-1:0] rx,
  input  portMaskT                portActive,
  input  boardIdT                 boardId,
  output portMaskT                fwdValid,
  output portMaskT [NumPorts-1:0] fwdMask
);

  portMaskT                hdrValid;           // Header strobe per in-port
  hdrInfoT  [NumPorts-1:0] hdrs;
  portMaskT [NumPorts-1:0] masks;              // Combinational decisions
  fwdTableT                fwdTable;

  for (genvar p = 0; p < NumPorts; p++) begin : gPort

    rxHeaderParser i_rxHeaderParser (
      .RxClk    (RxClk),
      .arstN    (arstN),
      .rx       (rx[p]),
      .hdrValid (hdrValid[p]),
      .hdr      (hdrs[p])
    );

    // Port role comes from the index
    fwdDecide #(
      .InPort (p)
    ) i_fwdDecide (
      .hdr        (hdrs[p]),
      .fwdTable   (fwdTable),
      .boardId    (boardId),
      .portActive (portActive),
      .mask       (masks[p])
    );

  end

  fwdControl i_fwdControl (
    .RxClk      (RxClk),
    .arstN      (arstN),
    .boardId    (boardId),
    .portActive (portActive),
    .hdrValid   (hdrValid),
    .hdrs       (hdrs),
    .masks      (masks),
    .fwdTable   (fwdTable),
    .fwdValid   (fwdValid),
    .fwdMask    (fwdMask)
  );

endmodule

// ==== tb/ethSwitch_asserts.sv ====
//##########################################################
// Decision strobe and mask assertions
// Bound into the forwarding control
//##########################################################

module ethSwitch_asserts import ethSwitchPkg::*; (
  input logic                    RxClk,
  input logic                    arstN,
  input portMaskT                portActive,
  input portMaskT                fwdValid,
  input portMaskT [NumPorts-1:0] fwdMask
);

  int       failCount = 0;                     // Assertion failures so far
  portMaskT ownBits;                           // Diagonal of the mask array

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      ownBits[p] = fwdMask[p][p];
    end
  end

  // Strobed in-port whose mask names a port that was down
  function automatic logic sentToInactive(input portMaskT v,
                                          input portMaskT [NumPorts-1:0] m,
                                          input portMaskT act);
    sentToInactive = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      sentToInactive |= v[p] && ((m[p] & ~act) != '0);
    end
  endfunction

  strobeOneCycle: assert property (@(posedge RxClk) disable iff (!arstN)
    (fwdValid & $past(fwdValid)) == '0)
    else begin
      failCount++;
      $error("fwdValid stayed high for two cycles");
    end

  noOwnPort: assert property (@(posedge RxClk) disable iff (!arstN) ownBits == '0)
    else begin
      failCount++;
      $error("in-port bit set in its own fwdMask");
    end

  // Mask was built from portActive one edge earlier
  noInactivePort: assert property (@(posedge RxClk) disable iff (!arstN)
    !sentToInactive(fwdValid, fwdMask, $past(portActive)))
    else begin
      failCount++;
      $error("fwdMask sends to an inactive port");
    end

endmodule

// ==== tb/fwdChecker.sv ====
//##########################################################
// Forwarding decision checker
// Waits for the fwdValid strobe of the armed in-port,
// checks its latency and mask, and flags stray strobes
//##########################################################

module fwdChecker import ethSwitchPkg::*; #(
  parameter int TimeoutCycles = 16
) (
  input  logic                    RxClk,
  input  portMaskT                fwdValid,
  input  portMaskT [NumPorts-1:0] fwdMask,
  input  logic                    expArm,       // High with the last header byte
  input  logic [1:0]              expPort,
  input  portMaskT                expMask,
  output int                      errCount,
  output int                      checkCount,
  output int                      doneCount     // Armed checks finished, pass or fail
);

  localparam int StrobeLatency = 2;            // Edges after the last header byte

  task automatic flagStray(input portMaskT allowed);
    portMaskT stray;
    stray = fwdValid & ~allowed;
    if (stray != '0) begin
      errCount++;
      $display("ERROR: unexpected fwdValid strobe on in-ports 0x%h", stray);
    end
  endtask

  task automatic checkDecision(input logic [1:0] port, input portMaskT mask);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    while (!seen && (edges <= TimeoutCycles)) begin
      @(negedge RxClk);                        // Outputs settled here
      flagStray(portMaskT'(1) << port);
      seen = fwdValid[port];
      if (!seen) begin
        @(posedge RxClk);
        edges++;
      end
    end
    if (!seen) begin
      errCount++;
      $display("ERROR: no fwdValid strobe from in-port %0d within %0d cycles",
               port, TimeoutCycles);
    end else begin
      checkCount++;
      if (edges != StrobeLatency) begin
        errCount++;
        $display("[FAIL] fwdValid[%0d] latency: expected 0x%h, got 0x%h",
                 port, StrobeLatency, edges);
      end
      if (fwdMask[port] !== mask) begin
        errCount++;
        $display("[FAIL] fwdMask[%0d]: expected 0x%h, got 0x%h", port, mask, fwdMask[port]);
      end
    end
    doneCount++;
  endtask

  initial begin
    errCount   = 0;
    checkCount = 0;
    doneCount  = 0;
    forever begin
      @(posedge RxClk);                        // Arm inputs change on the falling edge
      if (expArm) begin
        checkDecision(expPort, expMask);
      end else begin
        @(negedge RxClk);
        flagStray('0);                         // Nothing expected now
      end
    end
  end

endmodule

// ==== tb/ethSwitchTb.sv ====
//##########################################################
// Testbench for the switch address path
// Sends the frames of a table and lets the checker compare
// each decision with a mask derived by hand
//##########################################################

module ethSwitchTb import ethSwitchPkg::*; ();

  localparam int      NumEntries  = 14;
  localparam int      DrainCycles = 40;
  localparam boardIdT Board       = 4'd3;

  localparam macT MacPs      = {CompanyId, PsMid, 4'd0, Board};  // PS primary
  localparam macT MacHost    = 48'h0A1B2C3D4E5F;                 // Host behind Eth1
  localparam macT MacUnknown = 48'h02AABBCCDDEE;
  localparam macT MacPc      = 48'h021122334455;                 // Source on PS or RT
  localparam macT MacFpga5   = {CompanyId, RtMid, 8'h05};        // Board 5 behind Eth2
  localparam macT MacToFpga5 = {CompanyId, PsMid, 8'h05};
  localparam macT MacMcast   = {CompanyIdMcast, 16'h1234, 8'hFF};

  typedef struct {
    int       inPort;
    macT      dest;
    macT      src;
    portMaskT active;
    boardIdT  board;
    logic     shortHdr;                        // Valid drops inside the header
    portMaskT expMask;
  } stimEntryT;

  stimEntryT               stimTable [NumEntries];
  logic                    RxClk;
  logic                    arstN;
  rxByteT   [NumPorts-1:0] rx;
  portMaskT                portActive;
  boardIdT                 boardId;
  portMaskT                fwdValid;
  portMaskT [NumPorts-1:0] fwdMask;
  logic                    expArm;
  logic     [1:0]          expPort;
  portMaskT                expMask;
  int                      chkErrors;
  int                      chkCount;
  int                      chkDone;

  ethSwitchTop i_ethSwitchTop (
    .RxClk      (RxClk),
    .arstN      (arstN),
    .rx         (rx),
    .portActive (portActive),
    .boardId    (boardId),
    .fwdValid   (fwdValid),
    .fwdMask    (fwdMask)
  );

  fwdChecker #(
    .TimeoutCycles (16)
  ) i_fwdChecker (
    .RxClk      (RxClk),
    .fwdValid   (fwdValid),
    .fwdMask    (fwdMask),
    .expArm     (expArm),
    .expPort    (expPort),
    .expMask    (expMask),
    .errCount   (chkErrors),
    .checkCount (chkCount),
    .doneCount  (chkDone)
  );

  bind fwdControl ethSwitch_asserts i_ethSwitchAsserts (
    .RxClk      (RxClk),
    .arstN      (arstN),
    .portActive (portActive),
    .fwdValid   (fwdValid),
    .fwdMask    (fwdMask)
  );

  initial begin
    RxClk = 1'b0;
    forever #2 RxClk = ~RxClk;
  end

  // One byte per falling edge on one port
  task automatic driveByte(input int port, input logic vld, input byteT dat, input logic arm);
    @(negedge RxClk);
    rx[port].valid = vld;
    rx[port].data  = dat;
    expArm         = arm;
  endtask

  task automatic sendFrame(input stimEntryT e);
    logic [111:0] hdrBits;
    int           hdrLen;
    hdrBits = {e.dest, e.src, 16'h0800};
    hdrLen  = e.shortHdr ? 6 : HeaderBytes;   // Short one stops after the dest MAC
    @(negedge RxClk);
    portActive = e.active;
    boardId    = e.board;
    expPort    = 2'(e.inPort);
    expMask    = e.expMask;
    for (int i = 0; i < 7; i++) begin
      driveByte(e.inPort, 1'b1, 8'h55, 1'b0);  // Preamble
    end
    driveByte(e.inPort, 1'b1, SfdByte, 1'b0);
    for (int i = 0; i < hdrLen; i++) begin
      driveByte(e.inPort, 1'b1, hdrBits[111-8*i -: 8], (i == HeaderBytes - 1));
    end
    if (!e.shortHdr) begin
      for (int i = 0; i < 4; i++) begin
        driveByte(e.inPort, 1'b1, 8'hA0 + 8'(i), 1'b0);
      end
    end
    for (int i = 0; i < 3; i++) begin
      driveByte(e.inPort, 1'b0, 8'h00, 1'b0);
    end
  endtask

  initial begin
    int armed;
    int waited;
    int tbErrors;
    int assertErrors;
    rx         = '0;
    portActive = '1;
    boardId    = Board;
    arstN      = 1'b0;
    expArm     = 1'b0;
    expPort    = '0;
    expMask    = '0;
    armed      = 0;
    tbErrors   = 0;
    // Port, dest, src, active, board, short, expected mask
    stimTable[0]  = '{PortRt,   MacUnknown, MacPc,    4'hF, Board, 1'b0, 4'b0011};  // Flooded
    stimTable[1]  = '{PortRt,   MacPs,      MacPc,    4'hF, Board, 1'b0, 4'b0100};
    stimTable[2]  = '{PortPs,   BroadcastMac, MacPc,  4'hF, Board, 1'b0, 4'b1011};
    stimTable[3]  = '{PortPs,   BroadcastMac, MacPc,  4'hD, Board, 1'b0, 4'b1001};  // Eth2 down
    stimTable[4]  = '{PortPs,   MacMcast,   MacPc,    4'hF, Board, 1'b0, 4'b1011};
    stimTable[5]  = '{PortEth1, MacUnknown, MacHost,  4'hF, Board, 1'b0, 4'b0010};  // Learns H
    stimTable[6]  = '{PortRt,   MacHost,    MacPc,    4'hF, Board, 1'b0, 4'b0001};
    stimTable[7]  = '{PortPs,   MacToFpga5, MacPc,    4'hF, Board, 1'b0, 4'b0011};  // Unclaimed
    stimTable[8]  = '{PortEth2, MacHost,    MacFpga5, 4'hF, Board, 1'b0, 4'b0001};  // Learns 5
    stimTable[9]  = '{PortPs,   MacToFpga5, MacPc,    4'hF, Board, 1'b0, 4'b0010};
    stimTable[10] = '{PortRt,   MacHost,    MacPc,    4'hE, Board, 1'b0, 4'b0010};  // Eth1 down
    stimTable[11] = '{PortRt,   MacHost,    MacPc,    4'hF, Board, 1'b0, 4'b0011};  // H forgotten
    stimTable[12] = '{PortPs,   BroadcastMac, MacPc,  4'hF, Board, 1'b1, 4'b0000};  // No strobe
    stimTable[13] = '{PortPs,   BroadcastMac, MacPc,  4'hF, Board, 1'b0, 4'b1011};
    repeat (8) @(negedge RxClk);
    arstN = 1'b1;
    for (int i = 0; i < NumEntries; i++) begin
      sendFrame(stimTable[i]);
      if (!stimTable[i].shortHdr) begin
        armed++;
      end
    end
    waited = 0;
    while ((chkDone < armed) && (waited < DrainCycles)) begin
      @(posedge RxClk);
      waited++;
    end
    if (chkDone < armed) begin
      tbErrors++;
      $display("ERROR: checker finished only %0d of %0d decisions in time", chkDone, armed);
    end
    assertErrors = i_ethSwitchTop.i_fwdControl.i_ethSwitchAsserts.failCount;
    $display("Decisions checked %0d, errors: checker %0d, assertions %0d, testbench %0d",
             chkCount, chkErrors, assertErrors, tbErrors);
    if ((chkErrors + assertErrors + tbErrors) == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== ethSwitch.f ====
hdl/ethSwitchPkg.sv
hdl/rxHeaderParser.sv
hdl/fwdDecide.sv
hdl/fwdControl.sv
hdl/ethSwitchTop.sv
tb/ethSwitch_asserts.sv
tb/fwdChecker.sv
tb/ethSwitchTb.sv
